// ==== source/csi_rx_cfg.svh ====
`ifndef CSI_RX_CFG_SVH
`define CSI_RX_CFG_SVH

//////////////////////////////
// link framing
//////////////////////////////

// leader byte that opens every high-speed burst
`define CSI_SYNC_BYTE 8'hB8

//////////////////////////////
// image geometry
//////////////////////////////

// payload words per RAW8 line, 4 bytes each
`define CSI_LINE_WORDS 4

// pixel address wraps here
`define CSI_FRAME_WORDS 19200

`define CSI_ADDR_W 16

`endif

// ==== source/csi_lane_pkg.sv ====
package csi_lane_pkg;

	//////////////////////////////
	// per-lane data
	//////////////////////////////

	// one deserialized nibble, oldest bit in bit 0
	typedef logic [3:0] lane_nibble_t;

	// aligned byte out of one lane
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} lane_byte_t;

endpackage

// ==== source/csi_packet_pkg.sv ====
`include "csi_rx_cfg.svh"

package csi_packet_pkg;

	//////////////////////////////
	// data identifiers
	//////////////////////////////

	typedef enum logic [5:0] {
		DT_FRAME_START = 6'h00,
		DT_FRAME_END   = 6'h01,
		DT_RAW8        = 6'h2A
	} data_type_e;

	//////////////////////////////
	// packet path records
	//////////////////////////////

	typedef struct packed {
		logic        valid;
		logic [31:0] data;
	} csi_word_t;

	// decoded header, ECC byte itself dropped
	typedef struct packed {
		logic        valid;
		logic [1:0]  vc;
		data_type_e  data_type;
		logic [15:0] word_count;
		logic        ecc_corrected;
		logic        ecc_err;
	} csi_header_t;

	typedef struct packed {
		logic                   valid;
		logic [`CSI_ADDR_W-1:0] addr;
		logic [15:0]            x;
		logic [15:0]            y;
		logic [31:0]            data;
	} pixel_write_t;

	// one per header
	typedef struct packed {
		logic       valid;
		data_type_e data_type;
		logic       ecc_corrected;
		logic       ecc_err;
		logic       crc_ok;
	} packet_status_t;

endpackage

// ==== source/lane_aligner.sv ====
`include "csi_rx_cfg.svh"

module lane_aligner
	import csi_lane_pkg::*;
(
	input  logic         mipi_clk_2,
	input  logic         reset,
	input  logic         hs_active_i,
	input  lane_nibble_t nibble_i,
	output lane_byte_t   byte_o
);
	localparam logic [7:0] SYNC = `CSI_SYNC_BYTE;

	lane_nibble_t prev_q;
	logic [1:0]   carry_q;
	logic         locked_q;
	logic         off2_q;
	logic [1:0]   phase_q;
	logic [7:0]   window;
	logic         hit_0;
	logic         hit_2;

	// last two nibbles, newest on top
	assign window = {nibble_i, prev_q};

	// sync on a nibble edge, or starting two bits into one
	assign hit_0 = (window == SYNC);
	assign hit_2 = (window[7:2] == SYNC[5:0]);

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !hs_active_i) begin
			prev_q <= '0;
			carry_q <= '0;
			locked_q <= 1'b0;
			off2_q <= 1'b0;
			phase_q <= '0;
			byte_o.valid <= 1'b0;
		end else begin
			prev_q <= nibble_i;
			carry_q <= prev_q[3:2];
			byte_o.valid <= 1'b0;
			if (!locked_q) begin
				if (hit_0 || hit_2) begin
					locked_q <= 1'b1;
					off2_q <= !hit_0;
					// offset 2 ends one cycle later, so wait one more
					phase_q <= hit_0 ? 2'd1 : 2'd2;
				end
			end else if (phase_q == 2'd0) begin
				byte_o.valid <= 1'b1;
				if (off2_q) begin
					byte_o.data <= {nibble_i[1:0], prev_q, carry_q};
				end else begin
					byte_o.data <= window;
				end
				phase_q <= 2'd1;
			end else begin
				phase_q <= phase_q - 2'd1;
			end
		end
	end

endmodule

// ==== source/word_assembler.sv ====
module word_assembler
	import csi_lane_pkg::*;
	import csi_packet_pkg::*;
(
	input  logic       mipi_clk_2,
	input  logic       reset,
	input  logic       hs_active_i,
	input  lane_byte_t lane0_i,
	input  lane_byte_t lane1_i,
	output csi_word_t  word_o
);
	logic        upper_q;
	logic [15:0] low_q;
	logic        pair_valid;

	// lanes start together, so both strobes line up
	assign pair_valid = lane0_i.valid && lane1_i.valid;

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !hs_active_i) begin
			upper_q <= 1'b0;
			word_o.valid <= 1'b0;
		end else begin
			word_o.valid <= 1'b0;
			if (pair_valid) begin
				upper_q <= !upper_q;
				if (upper_q) begin
					word_o.valid <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// byte placement
	//////////////////////////////

	// lane0 lands in the lower byte of each pair
	always_ff @(posedge mipi_clk_2) begin
		if (pair_valid) begin
			if (upper_q) begin
				word_o.data <= {lane1_i.data, lane0_i.data, low_q};
			end else begin
				low_q <= {lane1_i.data, lane0_i.data};
			end
		end
	end

endmodule

// ==== source/header_ecc.sv ====
module header_ecc
	import csi_packet_pkg::*;
(
	input  logic        mipi_clk_2,
	input  logic        reset,
	input  logic        hs_active_i,
	input  csi_word_t   word_i,
	output csi_header_t header_o
);
	// header bits covered by each parity bit
	localparam logic [23:0] ECC_MASK [6] = '{
		24'hF12CB7,
		24'hF2555B,
		24'h749A6D,
		24'hB8E38E,
		24'hDF03F0,
		24'hEFFC00
	};

	logic        first_q;
	logic [5:0]  parity;
	logic [5:0]  syndrome;
	logic [5:0]  column;
	logic [23:0] fixed;
	logic        single;

	always_comb begin
		for (int p = 0; p < 6; p++) begin
			parity[p] = ^(word_i.data[23:0] & ECC_MASK[p]);
		end
		syndrome = parity ^ word_i.data[29:24];
		fixed = word_i.data[23:0];
		single = 1'b0;
		column = '0;
		// syndrome of a single data bit error is that bit's column
		for (int b = 0; b < 24; b++) begin
			for (int p = 0; p < 6; p++) begin
				column[p] = ECC_MASK[p][b];
			end
			if (syndrome == column) begin
				fixed[b] = !fixed[b];
				single = 1'b1;
			end
		end
	end

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !hs_active_i) begin
			first_q <= 1'b1;
			header_o.valid <= 1'b0;
		end else begin
			header_o.valid <= word_i.valid && first_q;
			if (word_i.valid) begin
				first_q <= 1'b0;
			end
			// only the first word of a burst is a header
			if (word_i.valid && first_q) begin
				header_o.vc <= fixed[7:6];
				header_o.data_type <= data_type_e'(fixed[5:0]);
				header_o.word_count <= fixed[23:8];
				header_o.ecc_corrected <= single;
				header_o.ecc_err <= (syndrome != 6'd0) && !single;
			end
		end
	end

endmodule

// ==== source/payload_crc.sv ====
module payload_crc
	import csi_packet_pkg::*;
(
	input  logic        mipi_clk_2,
	input  logic        reset,
	input  logic        clear_i,
	input  csi_word_t   word_i,
	output logic [15:0] crc_o
);
	localparam logic [15:0] CRC_POLY = 16'h8408;
	localparam logic [15:0] CRC_INIT = 16'hFFFF;

	logic [15:0] crc_q;

	// bit serial over the word, byte 0 first, each byte lsb first
	function automatic logic [15:0] crc_step(
		input logic [15:0] crc_in,
		input logic [31:0] data
	);
		logic [15:0] c;
		c = crc_in;
		for (int i = 0; i < 32; i++) begin
			if (c[0] ^ data[i]) begin
				c = (c >> 1) ^ CRC_POLY;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	//////////////////////////////
	// remainder register
	//////////////////////////////

	always_ff @(posedge mipi_clk_2) begin
		if (reset || clear_i) begin
			crc_q <= CRC_INIT;
		end else if (word_i.valid) begin
			crc_q <= crc_step(crc_q, word_i.data);
		end
	end

	assign crc_o = crc_q;

endmodule

// ==== source/packet_parser.sv ====
`include "csi_rx_cfg.svh"

module packet_parser
	import csi_packet_pkg::*;
(
	input  logic           mipi_clk_2,
	input  logic           reset,
	input  logic           hs_active_i,
	input  csi_header_t    header_i,
	input  csi_word_t      word_i,
	output pixel_write_t   pixel_o,
	output packet_status_t status_o
);
	localparam logic [`CSI_ADDR_W-1:0] ADDR_LAST = `CSI_ADDR_W'(`CSI_FRAME_WORDS - 1);
	localparam logic [15:0] X_LAST = 16'(`CSI_LINE_WORDS - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PAYLOAD,
		ST_CRC,
		ST_SKIP
	} parse_state_e;

	parse_state_e           state_q;
	logic [13:0]            words_left_q;
	logic [`CSI_ADDR_W-1:0] addr_q;
	logic [15:0]            x_q;
	logic [15:0]            y_q;
	logic                   crc_clear;
	csi_word_t              crc_word;
	logic [15:0]            crc;

	// crc restarts for every packet and only sees payload words
	assign crc_clear = (state_q == ST_IDLE);
	assign crc_word.valid = word_i.valid && (state_q == ST_PAYLOAD);
	assign crc_word.data = word_i.data;

	payload_crc i_payload_crc (
		.mipi_clk_2 (mipi_clk_2),
		.reset      (reset),
		.clear_i    (crc_clear),
		.word_i     (crc_word),
		.crc_o      (crc)
	);

	//////////////////////////////
	// packet FSM
	//////////////////////////////

	always_ff @(posedge mipi_clk_2) begin
		if (reset) begin
			state_q <= ST_IDLE;
			addr_q <= '0;
			x_q <= '0;
			y_q <= '0;
			pixel_o.valid <= 1'b0;
			status_o.valid <= 1'b0;
		end else begin
			pixel_o.valid <= 1'b0;
			status_o.valid <= 1'b0;
			if (!hs_active_i) begin
				// frame position survives burst gaps
				state_q <= ST_IDLE;
			end else begin
				case (state_q)
					ST_IDLE: begin
						if (header_i.valid) begin
							words_left_q <= header_i.word_count[15:2];
							status_o.data_type <= header_i.data_type;
							status_o.ecc_corrected <= header_i.ecc_corrected;
							status_o.ecc_err <= header_i.ecc_err;
							status_o.crc_ok <= 1'b0;
							if (header_i.ecc_err) begin
								status_o.valid <= 1'b1;
								state_q <= ST_SKIP;
							end else if (header_i.data_type == DT_RAW8) begin
								if (header_i.word_count[15:2] == 14'd0) begin
									state_q <= ST_CRC;
								end else begin
									state_q <= ST_PAYLOAD;
								end
							end else begin
								if (header_i.data_type == DT_FRAME_START) begin
									addr_q <= '0;
									x_q <= '0;
									y_q <= '0;
								end
								status_o.valid <= 1'b1;
								state_q <= ST_SKIP;
							end
						end
					end
					ST_PAYLOAD: begin
						if (word_i.valid) begin
							pixel_o.valid <= 1'b1;
							pixel_o.addr <= addr_q;
							pixel_o.x <= x_q;
							pixel_o.y <= y_q;
							pixel_o.data <= word_i.data;
							addr_q <= (addr_q == ADDR_LAST) ? '0 : addr_q + 1'b1;
							// line end
							if (x_q == X_LAST) begin
								x_q <= '0;
								y_q <= y_q + 16'd1;
							end else begin
								x_q <= x_q + 16'd1;
							end
							words_left_q <= words_left_q - 14'd1;
							if (words_left_q == 14'd1) begin
								state_q <= ST_CRC;
							end
						end
					end
					ST_CRC: begin
						if (word_i.valid) begin
							status_o.valid <= 1'b1;
							status_o.crc_ok <= (word_i.data[15:0] == crc);
							state_q <= ST_SKIP;
						end
					end
					default: begin
						// rest of the burst is ignored
						state_q <= ST_SKIP;
					end
				endcase
			end
		end
	end

endmodule

// ==== source/csi_rx_top.sv ====
module csi_rx_top
	import csi_lane_pkg::*;
	import csi_packet_pkg::*;
(
	input  logic           mipi_clk_2,
	input  logic           reset,
	input  logic           hs_active_i,
	input  lane_nibble_t   lane0_nibble_i,
	input  lane_nibble_t   lane1_nibble_i,
	output pixel_write_t   pixel_o,
	output packet_status_t status_o
);
	lane_byte_t  lane0_byte;
	lane_byte_t  lane1_byte;
	csi_word_t   word;
	csi_header_t header;

	//////////////////////////////
	// lane alignment
	//////////////////////////////

	lane_aligner i_lane0_aligner (
		.mipi_clk_2  (mipi_clk_2),
		.reset       (reset),
		.hs_active_i (hs_active_i),
		.nibble_i    (lane0_nibble_i),
		.byte_o      (lane0_byte)
	);

	lane_aligner i_lane1_aligner (
		.mipi_clk_2  (mipi_clk_2),
		.reset       (reset),
		.hs_active_i (hs_active_i),
		.nibble_i    (lane1_nibble_i),
		.byte_o      (lane1_byte)
	);

	//////////////////////////////
	// packet path
	//////////////////////////////

	word_assembler i_word_assembler (
		.mipi_clk_2  (mipi_clk_2),
		.reset       (reset),
		.hs_active_i (hs_active_i),
		.lane0_i     (lane0_byte),
		.lane1_i     (lane1_byte),
		.word_o      (word)
	);

	header_ecc i_header_ecc (
		.mipi_clk_2  (mipi_clk_2),
		.reset       (reset),
		.hs_active_i (hs_active_i),
		.word_i      (word),
		.header_o    (header)
	);

	packet_parser i_packet_parser (
		.mipi_clk_2  (mipi_clk_2),
		.reset       (reset),
		.hs_active_i (hs_active_i),
		.header_i    (header),
		.word_i      (word),
		.pixel_o     (pixel_o),
		.status_o    (status_o)
	);

endmodule

// ==== tb/csi_rx_chk.sv ====
`include "csi_rx_cfg.svh"

module csi_rx_chk
	import csi_packet_pkg::*;
(
	input logic           mipi_clk_2,
	input logic           reset,
	input logic           hs_active_i,
	input logic [15:0]    x_i,
	input pixel_write_t   pixel_i,
	input packet_status_t status_i
);
	// no pixel traffic between bursts
	a_pixel_in_burst: assert property (@(posedge mipi_clk_2) disable iff (reset)
		!hs_active_i |-> !pixel_i.valid)
		else $error("pixel write while no burst is active");

	a_column_range: assert property (@(posedge mipi_clk_2) disable iff (reset)
		x_i < 16'(`CSI_LINE_WORDS))
		else $error("column counter past the end of the line");

	a_one_strobe: assert property (@(posedge mipi_clk_2) disable iff (reset)
		!(pixel_i.valid && status_i.valid))
		else $error("pixel write and status in the same cycle");

	// reset leaves both strobes low
	a_reset_quiet: assert property (@(posedge mipi_clk_2)
		reset |=> !pixel_i.valid && !status_i.valid)
		else $error("output strobe high right after reset");

endmodule

bind packet_parser csi_rx_chk i_csi_rx_chk (
	.mipi_clk_2  (mipi_clk_2),
	.reset       (reset),
	.hs_active_i (hs_active_i),
	.x_i         (x_q),
	.pixel_i     (pixel_o),
	.status_i    (status_o)
);

// ==== tb/csi_rx_tb.sv ====
`include "csi_rx_cfg.svh"

module csi_rx_tb
	import csi_packet_pkg::*;
();
	localparam int TAIL = 16;
	localparam int GAP = 4;
	localparam logic [7:0] SYNC = `CSI_SYNC_BYTE;

	logic           mipi_clk_2;
	logic           reset;
	logic           hs_active;
	logic [3:0]     lane0_nibble;
	logic [3:0]     lane1_nibble;
	pixel_write_t   pixel;
	packet_status_t status;

	int             vec_dt [32];
	int             vec_wc [32];
	int             vec_off [32];
	logic [31:0]    vec_flip [32];
	int             vec_bad_crc [32];
	int             vec_corr [32];
	int             vec_err [32];
	int             vec_crc_ok [32];
	int             num_vec;
	logic [7:0]     burst_bytes [$];
	pixel_write_t   exp_pix_q [$];
	packet_status_t exp_stat_q [$];
	logic [31:0]    lcg_state;
	int             cycle_count;
	int             cycle_limit;
	string          test_name;
	logic [`CSI_ADDR_W-1:0] model_addr;
	logic [15:0]    model_x;
	logic [15:0]    model_y;

	csi_rx_top i_csi_rx_top (
		.mipi_clk_2     (mipi_clk_2),
		.reset          (reset),
		.hs_active_i    (hs_active),
		.lane0_nibble_i (lane0_nibble),
		.lane1_nibble_i (lane1_nibble),
		.pixel_o        (pixel),
		.status_o       (status)
	);

	initial begin
		mipi_clk_2 = 1'b0;
		forever #2 mipi_clk_2 = !mipi_clk_2;
	end

	//////////////////////////////
	// reference models
	//////////////////////////////

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// parity equations of the two-lane header code, P0 first
	function automatic logic [5:0] compute_header_ecc(input logic [23:0] d);
		logic [5:0] p;
		p[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13] ^ d[16]
			^ d[20] ^ d[21] ^ d[22] ^ d[23];
		p[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14] ^ d[17]
			^ d[20] ^ d[21] ^ d[22] ^ d[23];
		p[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15] ^ d[18]
			^ d[20] ^ d[21] ^ d[22];
		p[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15] ^ d[19]
			^ d[20] ^ d[21] ^ d[23];
		p[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18] ^ d[19]
			^ d[20] ^ d[22] ^ d[23];
		p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^ d[18]
			^ d[19] ^ d[21] ^ d[22] ^ d[23];
		return p;
	endfunction

	function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] b);
		logic [15:0] c;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			c = (c[0] ^ b[i]) ? ((c >> 1) ^ 16'h8408) : (c >> 1);
		end
		return c;
	endfunction

	// header, then payload and crc word for RAW8
	function automatic int data_cycles(input int idx);
		int bytes;
		bytes = (vec_dt[idx] == 'h2A) ? 8 + vec_wc[idx] : 4;
		return (vec_off[idx] + 8 + 4 * bytes + 3) / 4;
	endfunction

	// serial bit of one lane, leading idle bits first
	function automatic logic lane_bit(input int lane, input int off, input int pos);
		int p;
		int k;
		p = pos - off;
		k = p / 8 - 1;
		if (p < 0) begin
			return 1'b0;
		end else if (p < 8) begin
			return SYNC[p];
		end else if (2 * k + lane < burst_bytes.size()) begin
			return burst_bytes[2 * k + lane][p % 8];
		end else begin
			return 1'b0;
		end
	endfunction

	//////////////////////////////
	// checking
	//////////////////////////////

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (expected !== actual) begin
			stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	always @(negedge mipi_clk_2) begin
		if (!reset && pixel.valid === 1'b1) begin
			if (exp_pix_q.size() == 0) begin
				stop_on_error($sformatf("%s: pixel write that was not expected", test_name));
			end else begin
				check_value({test_name, " pixel"}, exp_pix_q.pop_front(), pixel);
			end
		end
		if (!reset && status.valid === 1'b1) begin
			if (exp_stat_q.size() == 0) begin
				stop_on_error($sformatf("%s: status that was not expected", test_name));
			end else begin
				check_value({test_name, " status"}, exp_stat_q.pop_front(), status);
			end
		end
	end

	always @(posedge mipi_clk_2) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			stop_on_error($sformatf("timeout, run still busy after %0d cycles", cycle_count));
		end
	end

	task automatic read_vectors();
		int fd;
		int n;
		string line;
		fd = $fopen("tb/csi_rx_vectors.txt", "r");
		if (fd == 0) begin
			stop_on_error("could not open the vector file tb/csi_rx_vectors.txt");
		end else begin
			num_vec = 0;
			while ($fgets(line, fd) != 0 && num_vec < 32) begin
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%h %d %d %h %d %d %d %d", vec_dt[num_vec],
						vec_wc[num_vec], vec_off[num_vec], vec_flip[num_vec],
						vec_bad_crc[num_vec], vec_corr[num_vec], vec_err[num_vec],
						vec_crc_ok[num_vec]);
					if (n == 8) begin
						num_vec++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	//////////////////////////////
	// burst builder
	//////////////////////////////

	task automatic send_burst(input int idx);
		logic [31:0]    hdr;
		logic [15:0]    crc;
		packet_status_t st;
		pixel_write_t   px;
		test_name = $sformatf("vector %0d", idx);
		burst_bytes.delete();
		hdr = {8'h00, vec_wc[idx][15:0], 2'b00, vec_dt[idx][5:0]};
		hdr[29:24] = compute_header_ecc(hdr[23:0]);
		hdr = hdr ^ vec_flip[idx];
		for (int i = 0; i < 4; i++) begin
			burst_bytes.push_back(hdr[8 * i +: 8]);
		end
		st.valid = 1'b1;
		st.data_type = data_type_e'((vec_err[idx] != 0) ? hdr[5:0] : vec_dt[idx][5:0]);
		st.ecc_corrected = vec_corr[idx][0];
		st.ecc_err = vec_err[idx][0];
		st.crc_ok = vec_crc_ok[idx][0];
		exp_stat_q.push_back(st);
		// frame start
		if (vec_err[idx] == 0 && vec_dt[idx] == 0) begin
			model_addr = '0;
			model_x = '0;
			model_y = '0;
		end
		if (vec_dt[idx] == 'h2A) begin
			crc = 16'hFFFF;
			for (int w = 0; w < vec_wc[idx] / 4; w++) begin
				lcg_state = lcg_step(lcg_state);
				for (int i = 0; i < 4; i++) begin
					burst_bytes.push_back(lcg_state[8 * i +: 8]);
					crc = crc16_byte(crc, lcg_state[8 * i +: 8]);
				end
				if (vec_err[idx] == 0) begin
					px.valid = 1'b1;
					px.addr = model_addr;
					px.x = model_x;
					px.y = model_y;
					px.data = lcg_state;
					exp_pix_q.push_back(px);
					model_addr = `CSI_ADDR_W'((int'(model_addr) + 1) % `CSI_FRAME_WORDS);
					model_x = model_x + 16'd1;
					if (model_x == 16'(`CSI_LINE_WORDS)) begin
						model_x = '0;
						model_y = model_y + 16'd1;
					end
				end
			end
			if (vec_bad_crc[idx] != 0) begin
				crc = crc ^ 16'h0001;
			end
			// crc word padded to four bytes
			burst_bytes.push_back(crc[7:0]);
			burst_bytes.push_back(crc[15:8]);
			burst_bytes.push_back(8'h00);
			burst_bytes.push_back(8'h00);
		end
		for (int c = 0; c < data_cycles(idx); c++) begin
			@(posedge mipi_clk_2);
			#1;
			hs_active = 1'b1;
			for (int b = 0; b < 4; b++) begin
				lane0_nibble[b] = lane_bit(0, vec_off[idx], 4 * c + b);
				lane1_nibble[b] = lane_bit(1, vec_off[idx], 4 * c + b);
			end
		end
		@(posedge mipi_clk_2);
		#1;
		lane0_nibble = '0;
		lane1_nibble = '0;
		// status strobe closes the packet
		while (exp_stat_q.size() != 0) begin
			@(posedge mipi_clk_2);
		end
		@(posedge mipi_clk_2);
		#1;
		hs_active = 1'b0;
		repeat (GAP) @(posedge mipi_clk_2);
	endtask

	initial begin
		int total;
		reset = 1'b1;
		hs_active = 1'b0;
		lane0_nibble = '0;
		lane1_nibble = '0;
		lcg_state = 32'd61;
		model_addr = '0;
		model_x = '0;
		model_y = '0;
		cycle_count = 0;
		total = 0;
		read_vectors();
		for (int i = 0; i < num_vec; i++) begin
			total = total + data_cycles(i) + TAIL + GAP;
		end
		cycle_limit = 2 * total + 50;
		repeat (2) @(posedge mipi_clk_2);
		#1;
		reset = 1'b0;
		for (int i = 0; i < num_vec; i++) begin
			send_burst(i);
		end
		if (num_vec > 0 && exp_pix_q.size() == 0 && exp_stat_q.size() == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			stop_on_error("no bursts were read, or expected writes are still pending");
		end
	end

endmodule

// ==== tb/csi_rx_vectors.txt ====
# data_type(hex) word_count lane_offset header_flip(hex) crc_corrupt
# expected: ecc_corrected ecc_err crc_ok
00 1 0 00000000 0 0 0 0
2A 16 0 00000000 0 0 0 1
2A 16 2 00000000 0 0 0 1
2A 16 0 00000400 0 1 0 1
2A 16 2 00000300 0 0 1 0
2A 16 0 00000000 1 0 0 0
00 2 2 00000000 0 0 0 0
2A 16 0 00000000 0 0 0 1
2A 32 2 00000000 0 0 0 1
01 2 0 00000000 0 0 0 0
12 8 2 00000000 0 0 0 0

// ==== build.f ====
+incdir+source
source/csi_lane_pkg.sv
source/csi_packet_pkg.sv
source/lane_aligner.sv
source/word_assembler.sv
source/header_ecc.sv
source/payload_crc.sv
source/packet_parser.sv
source/csi_rx_top.sv
tb/csi_rx_chk.sv
tb/csi_rx_tb.sv

// ==== Makefile ====
TOP = csi_rx_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
